// File: Makefile
TOP := tb_dl_top
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx 'TB PASSED' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
design/dl_pkg.sv
design/dl_byte_split.sv
design/dl_ctrl.sv
design/dl_cfg_bank.sv
design/dl_top.sv
test/tb_clk_gen.sv
test/tb_dl_top.sv

// File: design/dl_byte_split.sv
// Host write splitter: narrow mode registers byte writes, wide mode turns one 16-bit write into two
`default_nettype none

module dl_byte_split
    import dl_pkg::*;
#(
    parameter int WIDE      = 1,
    parameter int SPLIT_GAP = 8
)(
    input  wire                clk_rom,
    input  wire                rst,
    input  wire                host_wr,
    input  wire  [HOST_AW-1:0] host_addr,
    input  wire  [15:0]        host_data,
    output logic               byte_wr,
    output logic [ROM_AW-1:0]  byte_addr,
    output logic [7:0]         byte_data
);

    generate
        if (WIDE == 0) begin : g_narrow
            // One byte per host write, just a register stage
            always_ff @(posedge clk_rom or posedge rst) begin
                if (rst) begin
                    byte_wr <= 1'b0;
                end else begin
                    byte_wr <= host_wr;
                end
            end

            always_ff @(posedge clk_rom) begin
                if (host_wr) begin
                    byte_addr <= host_addr[ROM_AW-1:0];
                    byte_data <= host_data[7:0];
                end
            end
        end else begin : g_wide
            // One-hot delay line, bit k high k+1 cycles after the host strobe
            logic [SPLIT_GAP-1:0] st;
            logic [7:0]           hi_data;
            logic [ROM_AW-2:0]    addr_hi;
            logic                 pending;

            assign pending = |st;

            always_ff @(posedge clk_rom or posedge rst) begin
                if (rst) begin
                    st      <= '0;
                    byte_wr <= 1'b0;
                end else begin
                    st      <= {st[SPLIT_GAP-2:0], host_wr};
                    // Low byte right away, high byte when the last stage fires
                    byte_wr <= host_wr | st[SPLIT_GAP-1];
                end
            end

            // High byte and word address are kept for the second write
            always_ff @(posedge clk_rom) begin
                if (host_wr) begin
                    hi_data   <= host_data[15:8];
                    addr_hi   <= host_addr[ROM_AW-1:1];
                    byte_addr <= {host_addr[ROM_AW-1:1], 1'b0};
                    byte_data <= host_data[7:0];
                end else if (st[SPLIT_GAP-1]) begin
                    byte_addr <= {addr_hi, 1'b1};
                    byte_data <= hi_data;
                end
            end

            // Host has no back-pressure, so a new word must wait for the high byte
            a_no_overlap: assert property (
                @(posedge clk_rom) disable iff (rst)
                host_wr |-> !pending
            ) else $error("host write arrived while a byte split was pending");
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/dl_cfg_bank.sv
// Configuration bank: collects DIP switch bytes into one word and holds the core-mode register
`default_nettype none

module dl_cfg_bank
    import dl_pkg::*;
(
    input  wire                          clk_rom,
    input  wire                          rst,
    input  wire                          dip_we,
    input  wire  [$clog2(DIP_BYTES)-1:0] dip_sel,
    input  wire                          mod_we,
    input  wire  [7:0]                   cfg_data,
    output logic [DIP_BYTES*8-1:0]       dipsw,
    output logic [MOD_W-1:0]             core_mod
);

    // Switch bytes, byte 0 ends up in the low bits of dipsw
    logic [7:0] dsw [DIP_BYTES];

    // All ones until the DIP file arrives, the usual default for active-low switches
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DIP_BYTES; i++) begin
                dsw[i] <= 8'hff;
            end
        end else if (dip_we) begin
            dsw[dip_sel] <= cfg_data;
        end
    end

    always_comb begin
        for (int i = 0; i < DIP_BYTES; i++) begin
            dipsw[8*i +: 8] = dsw[i];
        end
    end

    // Mode byte, top bit is spare
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            core_mod <= MOD_RESET;
        end else if (mod_we) begin
            core_mod <= cfg_data[MOD_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: design/dl_ctrl.sv
// Download control: decodes file index and byte address into ROM, DIP and core-mode write strobes
`default_nettype none

module dl_ctrl
    import dl_pkg::*;
(
    input  wire                          clk_rom,
    input  wire                          rst,
    input  wire                          host_download,
    input  wire  [7:0]                   host_index,
    input  wire                          byte_wr,
    input  wire  [ROM_AW-1:0]            byte_addr,
    input  wire  [7:0]                   byte_data,
    output logic                         rom_wr,
    output logic [ROM_AW-1:0]            rom_addr,
    output logic [7:0]                   rom_data,
    output logic                         dip_we,
    output logic [$clog2(DIP_BYTES)-1:0] dip_sel,
    output logic                         mod_we,
    output logic [7:0]                   cfg_data,
    output logic                         downloading
);

    localparam int DSEL_W = $clog2(DIP_BYTES);

    logic is_rom;
    logic is_dip;
    logic is_mod;
    logic dip_hit;
    logic mod_hit;

    // Index stays put for the whole file, so a plain compare is enough
    assign is_rom = host_index == IDX_ROM;
    assign is_dip = host_index == IDX_DIP;
    assign is_mod = host_index == IDX_MOD;

    // Only the first few bytes of the DIP file are switch settings
    assign dip_hit = is_dip && (byte_addr < ROM_AW'(DIP_BYTES));

    // Wide host writes the mode byte twice; the odd copy would clobber it
    assign mod_hit = is_mod && !byte_addr[0];

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            rom_wr      <= 1'b0;
            dip_we      <= 1'b0;
            mod_we      <= 1'b0;
            downloading <= 1'b0;
        end else begin
            rom_wr      <= byte_wr && is_rom;
            dip_we      <= byte_wr && dip_hit;
            mod_we      <= byte_wr && mod_hit;
            // Busy flag for the ROM loader, mode and DIP files don't count
            downloading <= host_download && is_rom;
        end
    end

    // Payload follows the strobe, same cycle
    always_ff @(posedge clk_rom) begin
        if (byte_wr) begin
            rom_addr <= byte_addr;
            rom_data <= byte_data;
            cfg_data <= byte_data;
            dip_sel  <= byte_addr[DSEL_W-1:0];
        end
    end

    // Decode relies on the file index holding still during a download
    a_index_stable: assert property (
        @(posedge clk_rom) disable iff (rst)
        host_download && $past(host_download) |-> $stable(host_index)
    ) else $error("file index changed in the middle of a download");

endmodule

`default_nettype wire

// File: design/dl_pkg.sv
// Shared index codes, widths and reset values for the download path, imported by every RTL module
`default_nettype none

package dl_pkg;

    // Host file indices as sent by the firmware
    // Index 0 is always the main ROM file
    localparam logic [7:0] IDX_ROM = 8'd0;

    // Core-mode byte, loaded ahead of the ROM
    localparam logic [7:0] IDX_MOD = 8'd1;

    // DIP switch settings, taken from the game's description file
    localparam logic [7:0] IDX_DIP = 8'd254;

    // Host side address, wide enough for the largest file
    localparam int HOST_AW = 27;

    // Byte address on the ROM programming port
    // Upper host bits are dropped here
    localparam int ROM_AW = 25;

    // DIP switch word is built from this many bytes
    localparam int DIP_BYTES = 4;

    // Core-mode register
    // Bit 0 set means horizontal screen, the usual default
    localparam int MOD_W = 7;
    localparam logic [MOD_W-1:0] MOD_RESET = 7'd1;

endpackage

`default_nettype wire

// File: design/dl_top.sv
// Download path top level: host port in, ROM byte port, DIP switch word and core mode out
`default_nettype none

module dl_top
    import dl_pkg::*;
#(
    parameter int WIDE      = 1,
    parameter int SPLIT_GAP = 8
)(
    input  wire                    clk_rom,
    input  wire                    rst,
    // Host download port
    input  wire                    host_download,
    input  wire  [7:0]             host_index,
    input  wire                    host_wr,
    input  wire  [HOST_AW-1:0]     host_addr,
    input  wire  [15:0]            host_data,
    // ROM programming
    output logic                   rom_wr,
    output logic [ROM_AW-1:0]      rom_addr,
    output logic [7:0]             rom_data,
    output logic                   downloading,
    // Settings
    output logic [DIP_BYTES*8-1:0] dipsw,
    output logic [MOD_W-1:0]       core_mod
);

    logic                         byte_wr;
    logic [ROM_AW-1:0]            byte_addr;
    logic [7:0]                   byte_data;

    logic                         dip_we;
    logic [$clog2(DIP_BYTES)-1:0] dip_sel;
    logic                         mod_we;
    logic [7:0]                   cfg_data;

    dl_byte_split #(
        .WIDE      ( WIDE      ),
        .SPLIT_GAP ( SPLIT_GAP )
    ) u_split (
        .clk_rom   ( clk_rom   ),
        .rst       ( rst       ),
        .host_wr   ( host_wr   ),
        .host_addr ( host_addr ),
        .host_data ( host_data ),
        .byte_wr   ( byte_wr   ),
        .byte_addr ( byte_addr ),
        .byte_data ( byte_data )
    );

    dl_ctrl u_ctrl (
        .clk_rom       ( clk_rom       ),
        .rst           ( rst           ),
        .host_download ( host_download ),
        .host_index    ( host_index    ),
        .byte_wr       ( byte_wr       ),
        .byte_addr     ( byte_addr     ),
        .byte_data     ( byte_data     ),
        .rom_wr        ( rom_wr        ),
        .rom_addr      ( rom_addr      ),
        .rom_data      ( rom_data      ),
        .dip_we        ( dip_we        ),
        .dip_sel       ( dip_sel       ),
        .mod_we        ( mod_we        ),
        .cfg_data      ( cfg_data      ),
        .downloading   ( downloading   )
    );

    dl_cfg_bank u_cfg (
        .clk_rom  ( clk_rom  ),
        .rst      ( rst      ),
        .dip_we   ( dip_we   ),
        .dip_sel  ( dip_sel  ),
        .mod_we   ( mod_we   ),
        .cfg_data ( cfg_data ),
        .dipsw    ( dipsw    ),
        .core_mod ( core_mod )
    );

endmodule

`default_nettype wire

// File: test/dl_vectors.txt
# cmd index host_addr host_data rom_pair dipsw core_mod with values in hex
# S starts a file and E ends it while W is a host write with the expected results after it
S 01 0000000 0000 0000 ffffffff 01
W 01 0000000 1a05 0000 ffffffff 05
W 01 0000002 80b3 0000 ffffffff 33
E 01 0000000 0000 0000 ffffffff 33
S fe 0000000 0000 0000 ffffffff 33
W fe 0000000 5aa5 0000 ffff5aa5 33
W fe 0000002 c33c 0000 c33c5aa5 33
W fe 0000006 1234 0000 c33c5aa5 33
W fe 0000000 0f00 0000 c33c0f00 33
E fe 0000000 0000 0000 c33c0f00 33
S 00 0000000 0000 0000 c33c0f00 33
W 00 0000000 beef beef c33c0f00 33
W 00 0000002 1234 1234 c33c0f00 33
W 00 0001235 7e81 7e81 c33c0f00 33
W 00 1fffffe a55a a55a c33c0f00 33
W 00 600000a 00ff 00ff c33c0f00 33
E 00 0000000 0000 0000 c33c0f00 33
S 01 0000000 0000 0000 c33c0f00 33
W 01 0000000 7702 0000 c33c0f00 02
E 01 0000000 0000 0000 c33c0f00 02

// File: test/tb_clk_gen.sv
// Testbench clock and reset source, a free-running clk_rom and a reset pulse at the start of the run
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 4
)(
    output logic clk_rom,
    output logic rst
);

    initial begin
        clk_rom = 1'b0;
        forever #(PERIOD / 2) clk_rom = ~clk_rom;
    end

    // Released on a rising edge, like a synchronized reset would be
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_rom);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: test/tb_dl_top.sv
// Testbench for the download path, replays host files from the vector file and checks all outputs
`default_nettype none

module tb_dl_top
    import dl_pkg::*;
();

    localparam int SPLIT_GAP   = 8;
    localparam int WR_SPACING  = 12;
    localparam int ROM_TIMEOUT = 20;
    localparam int RST_TIMEOUT = 20;

    wire clk_rom;
    wire rst;

    // Host port
    logic               host_download;
    logic [7:0]         host_index;
    logic               host_wr;
    logic [HOST_AW-1:0] host_addr;
    logic [15:0]        host_data;

    wire                   rom_wr;
    wire [ROM_AW-1:0]      rom_addr;
    wire [7:0]             rom_data;
    wire                   downloading;
    wire [DIP_BYTES*8-1:0] dipsw;
    wire [MOD_W-1:0]       core_mod;

    int           fd;
    int           code;
    int           n_lines;
    logic         eof_seen;
    logic [7:0]   cmd;
    logic [7:0]   cur_index;
    logic         in_file;

    // One vector line
    logic [7:0]         v_idx;
    logic [HOST_AW-1:0] v_addr;
    logic [15:0]        v_data;
    logic [15:0]        v_pair;
    logic [31:0]        v_dip;
    logic [MOD_W-1:0]   v_mod;

    tb_clk_gen #(
        .PERIOD     ( 4 ),
        .RST_CYCLES ( 4 )
    ) u_clk (
        .clk_rom ( clk_rom ),
        .rst     ( rst     )
    );

    dl_top #(
        .WIDE      ( 1         ),
        .SPLIT_GAP ( SPLIT_GAP )
    ) dut0 (
        .clk_rom       ( clk_rom       ),
        .rst           ( rst           ),
        .host_download ( host_download ),
        .host_index    ( host_index    ),
        .host_wr       ( host_wr       ),
        .host_addr     ( host_addr     ),
        .host_data     ( host_data     ),
        .rom_wr        ( rom_wr        ),
        .rom_addr      ( rom_addr      ),
        .rom_data      ( rom_data      ),
        .downloading   ( downloading   ),
        .dipsw         ( dipsw         ),
        .core_mod      ( core_mod      )
    );

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    // Rest of a comment line in the vector file
    task automatic skip_line();
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    // Idle cycle, no ROM write expected here
    task automatic watch_cycle();
        @(negedge clk_rom);
        check(32'(downloading), 32'(in_file && cur_index == IDX_ROM), "downloading");
        check(32'(rom_wr), 32'd0, "rom_wr");
    endtask

    task automatic wait_rom_wr(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_rom);
            cycles++;
            check(32'(downloading), 32'd1, "downloading");
        end while (!rom_wr && cycles < ROM_TIMEOUT);
        if (!rom_wr) begin
            abort_run("no ROM write seen within 20 cycles");
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk_rom);
            n++;
        end while (rst !== 1'b0 && n < RST_TIMEOUT);
        if (rst !== 1'b0) begin
            abort_run("reset was never released");
        end
    endtask

    task automatic start_file(input logic [7:0] idx);
        @(posedge clk_rom);
        host_download <= 1'b1;
        host_index    <= idx;
        cur_index = idx;
        // Flag lags the host by one cycle
        watch_cycle();
        in_file = 1'b1;
        watch_cycle();
    endtask

    task automatic end_file();
        @(posedge clk_rom);
        host_download <= 1'b0;
        watch_cycle();
        in_file = 1'b0;
        watch_cycle();
    endtask

    // One 16-bit host write, then the rest of the slot up to the next write
    task automatic host_write(input logic [HOST_AW-1:0] addr, input logic [15:0] data,
                              input logic [15:0] exp_pair);
        logic [ROM_AW-1:0] lo_addr;
        logic [ROM_AW-1:0] hi_addr;
        int                lat;
        int                used;
        lo_addr = ROM_AW'(addr) & ~ROM_AW'(1);
        hi_addr = lo_addr | ROM_AW'(1);
        used    = 0;
        @(posedge clk_rom);
        host_wr   <= 1'b1;
        host_addr <= addr;
        host_data <= data;
        @(posedge clk_rom);
        host_wr <= 1'b0;
        if (cur_index == IDX_ROM) begin
            wait_rom_wr(lat);
            check(32'(lat), 32'd2, "low byte latency");
            check(32'(rom_addr), 32'(lo_addr), "rom_addr of low byte");
            check(32'(rom_data), 32'(exp_pair[7:0]), "rom_data of low byte");
            used = lat;
            wait_rom_wr(lat);
            check(32'(lat), 32'(SPLIT_GAP), "gap to high byte");
            check(32'(rom_addr), 32'(hi_addr), "rom_addr of high byte");
            check(32'(rom_data), 32'(exp_pair[15:8]), "rom_data of high byte");
            used += lat;
        end
        for (int i = used; i < WR_SPACING - 1; i++) begin
            watch_cycle();
        end
    endtask

    initial begin
        n_lines       = 0;
        eof_seen      = 1'b0;
        in_file       = 1'b0;
        cur_index     = 8'd0;
        host_download = 1'b0;
        host_index    = 8'd0;
        host_wr       = 1'b0;
        host_addr     = '0;
        host_data     = 16'd0;

        fd = $fopen("test/dl_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/dl_vectors.txt");
        end

        wait_reset_release();
        check(32'(core_mod), 32'd1, "core_mod after reset");
        check(32'(dipsw), 32'hffff_ffff, "dipsw after reset");
        check(32'(downloading), 32'd0, "downloading after reset");
        check(32'(rom_wr), 32'd0, "rom_wr after reset");

        while (!eof_seen) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                eof_seen = 1'b1;
            end else if (cmd == "#") begin
                skip_line();
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h", v_idx, v_addr, v_data, v_pair,
                               v_dip, v_mod);
                if (code != 6) begin
                    abort_run("malformed line in the vector file");
                end
                n_lines++;
                case (cmd)
                    "S": start_file(v_idx);
                    "W": host_write(v_addr, v_data, v_pair);
                    "E": end_file();
                    default: abort_run("unknown command in the vector file");
                endcase
                // Settings must have landed by the end of every line
                check(32'(dipsw), v_dip, "dipsw");
                check(32'(core_mod), 32'(v_mod), "core_mod");
            end
        end
        $fclose(fd);

        if (n_lines > 0) begin
            $display("TB PASSED");
        end else begin
            $display("no vectors were applied");
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
